//--- test/coreGolden.txt
# test l1Valid l1Pc l1Instr l0Valid l0Pc l0Instr, then per lane (lane 1 first) the commit
# valid regWrite rd data isSlot, then redirect valid pc; test is decimal, the rest hex
1 1 00400000 24011234 1 00400004 2402FFF0 1 1 01 00001234 0 1 1 02 FFFFFFF0 0 0 00000000
1 1 00400008 00221821 1 0040000C 00222023 1 1 03 00001224 0 1 1 04 00001244 0 0 00000000
1 1 00400010 00622824 1 00400014 00813025 1 1 05 00001220 0 1 1 06 00001274 0 0 00000000
1 0 00000000 00000000 0 00000000 00000000 0 0 00 00000000 0 0 0 00 00000000 0 0 00000000
1 1 00400018 00A13826 1 0040001C 0041402A 1 1 07 00000014 0 1 1 08 00000001 0 0 00000000
1 1 00400020 00064900 1 00400024 00025202 1 1 09 00012740 0 1 1 0A 00FFFFFF 0 0 00000000
1 1 00400028 304B8F0F 1 0040002C 352C000F 1 1 0B 00008F00 0 1 1 0C 0001274F 0 0 00000000
1 1 00400030 3C0DABCD 1 00400034 258EFFFF 1 1 0D ABCD0000 0 1 1 0E 0001274E 0 0 00000000
2 1 00400100 240F0011 1 00400104 240F0022 1 1 0F 00000011 0 1 1 0F 00000022 0 0 00000000
2 1 00400108 01E00821 1 0040010C 00208021 1 1 01 00000022 0 1 1 10 00001234 0 0 00000000
2 0 00000000 00000000 0 00000000 00000000 0 0 00 00000000 0 0 0 00 00000000 0 0 00000000
2 1 00400110 01E18821 1 00400114 01F09023 1 1 11 00000044 0 1 1 12 FFFFEDEE 0 0 00000000
3 1 00400200 24000055 1 00400204 00009821 1 1 00 00000055 0 1 1 13 00000000 0 0 00000000
3 1 00400208 24140007 1 0040020C 000DA821 1 1 14 00000007 0 1 1 15 ABCD0000 0 0 00000000
3 0 00000000 00000000 0 00000000 00000000 0 0 00 00000000 0 0 0 00 00000000 0 0 00000000
3 1 00400210 0014B021 1 00400214 0014B823 1 1 16 00000007 0 1 1 17 FFFFFFF9 0 0 00000000
4 1 90000100 08123456 1 90000104 24180030 1 0 00 00000000 0 1 1 18 00000030 1 1 9048D158
4 1 A0000200 0C100040 1 A0000204 0300C821 1 1 1F A0000208 0 1 1 19 00000030 1 1 A0400100
4 1 B0000300 341A4F00 1 B0000304 03E00008 1 1 1A 00004F00 0 1 0 00 00000000 0 1 A0000208
4 1 B0000400 03400008 1 B0000404 08000080 1 0 00 00000000 0 1 0 00 00000000 1 1 00004F00
5 0 C0000000 24010999 1 C0000004 FC01FFFF 0 0 00 00000000 0 1 0 00 00000000 0 0 00000000
5 1 C0000008 0021103F 0 C000000C 0C000001 1 0 02 00000000 0 0 0 00 00000000 0 0 00000000
5 1 C0000010 003FD821 1 C0000014 0040E021 1 1 1B A000022A 0 1 1 1C FFFFFFF0 0 0 00000000

//--- sources.f
hw/cpuPkg.sv
hw/instrDecoder.sv
hw/decode.sv
hw/regFile.sv
hw/execute.sv
hw/result.sv
hw/dualIssueCore.sv
test/coreTb.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= coreTb
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with $(SIM), run it and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/coreTb.sv
`timescale 1ns/100ps

module coreTb;
    // expected commit of one lane
    typedef struct packed {
        logic valid;
        logic regWrite;
        logic [4:0] rd;
        logic [31:0] data;
        logic isSlot;
    } laneExp_t;

    // one presented bundle plus what it should produce
    typedef struct packed {
        int test;
        int cycle;
        logic last;
        cpuPkg::fetchData_t [1:0] fetch;
        laneExp_t [1:0] lane;
        logic redirValid;
        logic [31:0] redirPc;
    } bundle_t;

    logic clk;
    logic rst;
    cpuPkg::fetchData_t [1:0] fetch;
    cpuPkg::commitData_t [1:0] commit;
    logic redirectValid;
    cpuPkg::word_t redirectPc;

    bundle_t golden[$];
    bundle_t redirQ[$];
    bundle_t commitQ[$];
    integer seed;
    int cycle;
    int checks;
    int errors;
    int testChecks[8];
    int testErrors[8];

    dualIssueCore i_dualIssueCore (
        .clk(clk),
        .rst(rst),
        .fetch(fetch),
        .commit(commit),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc)
    );

    always #20 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected, input int test);
        checks++;
        testChecks[test]++;
        if (actual !== expected) begin
            errors++;
            testErrors[test]++;
            $display("ERROR test %0d %s: expected %h, got %h", test, name, expected, actual);
        end
    endtask

    task automatic reportTest(input int test);
        $display("test %0d finished: %0d checks, %0d errors",
                 test, testChecks[test], testErrors[test]);
    endtask

    // nothing may leave the pipe in test 6
    task automatic checkQuiet();
        checkValue("commit[1].valid", 32'(commit[1].valid), 32'h0, 6);
        checkValue("commit[0].valid", 32'(commit[0].valid), 32'h0, 6);
        checkValue("redirectValid", 32'(redirectValid), 32'h0, 6);
    endtask

    task automatic loadGolden();
        int fd;
        int n;
        string line;
        logic [31:0] f [19];
        bundle_t b;
        fd = $fopen("test/coreGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open test/coreGolden.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip column notes and blank lines
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
            if (n == 19) begin
                b = '0;
                b.test = f[0];
                b.fetch[1].valid = f[1][0];
                b.fetch[1].pc = f[2];
                b.fetch[1].instr = f[3];
                b.fetch[0].valid = f[4][0];
                b.fetch[0].pc = f[5];
                b.fetch[0].instr = f[6];
                // lane 1 columns come first
                b.lane[1] = {f[7][0], f[8][0], f[9][4:0], f[10], f[11][0]};
                b.lane[0] = {f[12][0], f[13][0], f[14][4:0], f[15], f[16][0]};
                b.redirValid = f[17][0];
                b.redirPc = f[18];
                golden.push_back(b);
            end else if (n > 0) begin
                $display("malformed line in the golden file: %s", line);
                errors++;
            end
        end
        $fclose(fd);
        // mark where each test ends
        foreach (golden[i]) begin
            if (i == golden.size() - 1) begin
                golden[i].last = 1'b1;
            end else begin
                golden[i].last = golden[i + 1].test != golden[i].test;
            end
        end
    endtask

    // redirect one edge after presentation, commit two edges after
    task automatic checkDue();
        bundle_t b;
        if (redirQ.size() != 0 && redirQ[0].cycle + 1 == cycle) begin
            b = redirQ.pop_front();
            checkValue("redirectValid", 32'(redirectValid), 32'(b.redirValid), b.test);
            if (b.redirValid) begin
                checkValue("redirectPc", redirectPc, b.redirPc, b.test);
            end
        end
        if (commitQ.size() != 0 && commitQ[0].cycle + 2 == cycle) begin
            b = commitQ.pop_front();
            for (int i = 1; i >= 0; i--) begin
                checkValue($sformatf("commit[%0d].valid", i), 32'(commit[i].valid),
                           32'(b.lane[i].valid), b.test);
                // other fields only mean something on a valid lane
                if (b.lane[i].valid) begin
                    checkValue($sformatf("commit[%0d].pc", i), commit[i].pc,
                               b.fetch[i].pc, b.test);
                    checkValue($sformatf("commit[%0d].regWrite", i), 32'(commit[i].regWrite),
                               32'(b.lane[i].regWrite), b.test);
                    checkValue($sformatf("commit[%0d].rd", i), 32'(commit[i].rd),
                               32'(b.lane[i].rd), b.test);
                    checkValue($sformatf("commit[%0d].isSlot", i), 32'(commit[i].isSlot),
                               32'(b.lane[i].isSlot), b.test);
                    if (b.lane[i].regWrite) begin
                        checkValue($sformatf("commit[%0d].data", i), commit[i].data,
                                   b.lane[i].data, b.test);
                    end
                end
            end
            if (b.last) begin
                reportTest(b.test);
            end
        end
    endtask

    task automatic present(input bundle_t b);
        bundle_t entry;
        entry = b;
        @(negedge clk);
        cycle++;
        checkDue();
        fetch = entry.fetch;
        entry.cycle = cycle;
        redirQ.push_back(entry);
        commitQ.push_back(entry);
    endtask

    // empty bundle with junk in the instruction words
    function automatic bundle_t makeBubble(input int test);
        bundle_t b;
        b = '0;
        b.test = test;
        b.fetch[1].instr = $random(seed);
        b.fetch[0].instr = $random(seed);
        return b;
    endfunction

    initial begin
        int prevTest;
        int nBubbles;
        int guard;
        seed = 39579;
        clk = 1'b0;
        rst = 1'b1;
        fetch = '0;
        cycle = 0;
        checks = 0;
        errors = 0;
        foreach (testChecks[i]) begin
            testChecks[i] = 0;
            testErrors[i] = 0;
        end
        loadGolden();
        if (golden.size() == 0) begin
            $display("no bundles were read from the golden file");
            errors++;
        end else begin
            // valid junk during reset must be flushed
            for (int i = 0; i < 4; i++) begin
                fetch[1].valid = 1'b1;
                fetch[1].pc = $random(seed);
                fetch[1].instr = $random(seed);
                fetch[0].valid = 1'b1;
                fetch[0].pc = $random(seed);
                fetch[0].instr = $random(seed);
                @(negedge clk);
                checkQuiet();
            end
            rst = 1'b0;
            fetch = '0;
            // idle cycles after reset
            repeat (3) begin
                @(negedge clk);
                checkQuiet();
            end
            reportTest(6);
            prevTest = -1;
            foreach (golden[i]) begin
                // random gap between tests
                if (golden[i].test != prevTest) begin
                    nBubbles = 1 + ({$random(seed)} % 3);
                    repeat (nBubbles) begin
                        present(makeBubble(golden[i].test));
                    end
                    prevTest = golden[i].test;
                end
                present(golden[i]);
            end
            // drain the last two bundles
            guard = 0;
            while ((redirQ.size() != 0 || commitQ.size() != 0) && guard < 10) begin
                @(negedge clk);
                cycle++;
                checkDue();
                fetch = '0;
                guard++;
            end
            if (redirQ.size() != 0 || commitQ.size() != 0) begin
                $display("timed out while waiting for the last commits");
                errors++;
            end
        end
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hw/dualIssueCore.sv
`timescale 1ns/100ps

module dualIssueCore (
    input logic clk,
    input logic rst,
    input cpuPkg::fetchData_t [1:0] fetch,
    output cpuPkg::commitData_t [1:0] commit,
    output logic redirectValid,
    output cpuPkg::word_t redirectPc
);
    cpuPkg::decodeData_t [1:0] dataD;
    cpuPkg::execData_t [1:0] dataE;
    cpuPkg::word_t [3:0] rdata;
    logic [1:0] wen;
    cpuPkg::regAddr_t [1:0] waddr;
    cpuPkg::word_t [1:0] wdata;

    decode u_decode (.fetch(fetch), .dataD(dataD));

    // ports 0/1 lane 0 rs/rt, ports 2/3 lane 1 rs/rt
    regFile u_regFile (
        .clk(clk), .rst(rst),
        .raddr({dataD[1].rt, dataD[1].rs, dataD[0].rt, dataD[0].rs}),
        .rdata(rdata),
        .wen(wen), .waddr(waddr), .wdata(wdata)
    );

    execute u_execute (
        .clk(clk), .rst(rst), .dataD(dataD), .rdata(rdata),
        .resultBypass(commit), .dataE(dataE),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    result u_result (
        .clk(clk), .rst(rst), .dataE(dataE), .commit(commit),
        .wen(wen), .waddr(waddr), .wdata(wdata)
    );

endmodule

//--- hw/result.sv
`timescale 1ns/100ps

module result (
    input logic clk,
    input logic rst,
    input cpuPkg::execData_t [1:0] dataE,
    output cpuPkg::commitData_t [1:0] commit,
    output logic [1:0] wen,
    output cpuPkg::regAddr_t [1:0] waddr,
    output cpuPkg::word_t [1:0] wdata
);
    cpuPkg::commitData_t [1:0] commitQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            commitQ <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                commitQ[i].valid <= dataE[i].valid;
                commitQ[i].pc <= dataE[i].pc;
                commitQ[i].rd <= dataE[i].rd;
                commitQ[i].regWrite <= dataE[i].regWrite;
                commitQ[i].data <= dataE[i].result;
                commitQ[i].isSlot <= dataE[i].isSlot;
            end
        end
    end

    assign commit = commitQ;

    // writes to r0 dropped here
    // lane 1 yields to lane 0 on the same register
    assign wen[0] = commitQ[0].valid && commitQ[0].regWrite && commitQ[0].rd != '0;
    assign wen[1] = commitQ[1].valid && commitQ[1].regWrite && commitQ[1].rd != '0
                    && !(wen[0] && commitQ[0].rd == commitQ[1].rd);
    assign waddr[0] = commitQ[0].rd;
    assign waddr[1] = commitQ[1].rd;
    assign wdata[0] = commitQ[0].data;
    assign wdata[1] = commitQ[1].data;

    for (genvar i = 0; i < 2; i++) begin : g_chk
        noR0Write: assert property (@(posedge clk) disable iff (rst)
            (commit[i].regWrite && commit[i].rd == '0) |-> !wen[i]);
    end

endmodule

//--- hw/execute.sv
`timescale 1ns/100ps

module execute (
    input logic clk,
    input logic rst,
    input cpuPkg::decodeData_t [1:0] dataD,
    input cpuPkg::word_t [3:0] rdata,
    input cpuPkg::commitData_t [1:0] resultBypass,
    output cpuPkg::execData_t [1:0] dataE,
    output logic redirectValid,
    output cpuPkg::word_t redirectPc
);
    cpuPkg::decodeData_t [1:0] ctrlQ;
    cpuPkg::word_t [1:0] srcA;
    cpuPkg::word_t [1:0] srcB;
    cpuPkg::word_t [1:0] srcAQ;
    cpuPkg::word_t [1:0] srcBQ;
    cpuPkg::word_t [1:0] aluOut;
    cpuPkg::word_t [1:0] target;
    logic [1:0] jumpLane;

    // newest producer first
    // execute lane 0, lane 1, then result, then regfile
    function automatic cpuPkg::word_t forwardOperand(
        input cpuPkg::regAddr_t addr,
        input cpuPkg::word_t fileVal,
        input cpuPkg::execData_t [1:0] exe,
        input cpuPkg::commitData_t [1:0] res
    );
        if (addr == '0) return '0;
        if (exe[0].valid && exe[0].regWrite && exe[0].rd == addr) return exe[0].result;
        if (exe[1].valid && exe[1].regWrite && exe[1].rd == addr) return exe[1].result;
        if (res[0].valid && res[0].regWrite && res[0].rd == addr) return res[0].data;
        if (res[1].valid && res[1].regWrite && res[1].rd == addr) return res[1].data;
        return fileVal;
    endfunction

    // operand select during decode cycle
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            srcA[i] = forwardOperand(dataD[i].rs, rdata[2*i], dataE, resultBypass);
            srcB[i] = forwardOperand(dataD[i].rt, rdata[2*i+1], dataE, resultBypass);
            if (dataD[i].useImm) begin
                srcB[i] = dataD[i].signExt ? {{16{dataD[i].imm[15]}}, dataD[i].imm}
                                           : {16'h0000, dataD[i].imm};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlQ <= '0;
            srcAQ <= '0;
            srcBQ <= '0;
        end else begin
            ctrlQ <= dataD;
            srcAQ <= srcA;
            srcBQ <= srcB;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            case (ctrlQ[i].aluOp)
                cpuPkg::aluAdd: aluOut[i] = srcAQ[i] + srcBQ[i];
                cpuPkg::aluSub: aluOut[i] = srcAQ[i] - srcBQ[i];
                cpuPkg::aluAnd: aluOut[i] = srcAQ[i] & srcBQ[i];
                cpuPkg::aluOr: aluOut[i] = srcAQ[i] | srcBQ[i];
                cpuPkg::aluXor: aluOut[i] = srcAQ[i] ^ srcBQ[i];
                cpuPkg::aluSlt: aluOut[i] = {31'b0, $signed(srcAQ[i]) < $signed(srcBQ[i])};
                // shifts act on rt
                cpuPkg::aluSll: aluOut[i] = srcBQ[i] << ctrlQ[i].shamt;
                cpuPkg::aluSrl: aluOut[i] = srcBQ[i] >> ctrlQ[i].shamt;
                cpuPkg::aluLui: aluOut[i] = {ctrlQ[i].imm, 16'h0000};
                cpuPkg::aluPassPc8: aluOut[i] = ctrlQ[i].pc + 32'd8;
                default: aluOut[i] = '0;
            endcase
            dataE[i].valid = ctrlQ[i].valid;
            dataE[i].pc = ctrlQ[i].pc;
            dataE[i].rd = ctrlQ[i].rd;
            dataE[i].regWrite = ctrlQ[i].regWrite;
            dataE[i].result = aluOut[i];
            dataE[i].isSlot = ctrlQ[i].isSlot;
            // jr takes rs, j and jal take the pc+4 region
            jumpLane[i] = ctrlQ[i].valid && (ctrlQ[i].isJump || ctrlQ[i].isJr);
            target[i] = (ctrlQ[i].pc + 32'd4) & 32'hf000_0000;
            target[i] = ctrlQ[i].isJr ? srcAQ[i]
                                      : {target[i][31:28], ctrlQ[i].jumpIndex, 2'b00};
        end
    end

    // older lane wins if both jump
    assign redirectValid = |jumpLane;
    assign redirectPc = jumpLane[1] ? target[1] : target[0];

    // redirect only one cycle after a jump was decoded
    redirectSource: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> $past(
            (dataD[1].valid && (dataD[1].isJump || dataD[1].isJr)) ||
            (dataD[0].valid && (dataD[0].isJump || dataD[0].isJr))));

endmodule

//--- hw/regFile.sv
`timescale 1ns/100ps

module regFile (
    input logic clk,
    input logic rst,
    input cpuPkg::regAddr_t [3:0] raddr,
    output cpuPkg::word_t [3:0] rdata,
    input logic [1:0] wen,
    input cpuPkg::regAddr_t [1:0] waddr,
    input cpuPkg::word_t [1:0] wdata
);
    cpuPkg::word_t regs [31:0];

    // async read, r0 hardwired
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata[i] = (raddr[i] == '0) ? '0 : regs[raddr[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // lane 0 written last so it wins on a clash
            if (wen[1] && waddr[1] != '0) begin
                regs[waddr[1]] <= wdata[1];
            end
            if (wen[0] && waddr[0] != '0) begin
                regs[waddr[0]] <= wdata[0];
            end
        end
    end

    // storage behind r0 never changes once out of reset
    r0Zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

//--- hw/decode.sv
`timescale 1ns/100ps

module decode (
    input cpuPkg::fetchData_t [1:0] fetch,
    output cpuPkg::decodeData_t [1:0] dataD
);
    cpuPkg::decodeData_t [1:0] decRaw;

    // lane 1 is the older instruction
    instrDecoder lane1Decoder (
        .instr(fetch[1].instr),
        .valid(fetch[1].valid),
        .dec(decRaw[1])
    );

    instrDecoder lane0Decoder (
        .instr(fetch[0].instr),
        .valid(fetch[0].valid),
        .dec(decRaw[0])
    );

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dataD[i] = decRaw[i];
            dataD[i].pc = fetch[i].pc;
            dataD[i].imm = fetch[i].instr[15:0];
            dataD[i].shamt = fetch[i].instr[10:6];
            dataD[i].isSlot = 1'b0;
        end
        // younger lane sits in the delay slot of a jumping older lane
        dataD[0].isSlot = fetch[0].valid && (decRaw[1].isJump || decRaw[1].isJr);
    end

    always_comb begin
        assert (!dataD[0].isSlot || dataD[0].valid);
    end

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input cpuPkg::instr_t instr,
    input logic valid,
    output cpuPkg::decodeData_t dec
);
    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];

    always_comb begin
        // pc, imm, shamt and isSlot are filled in by decode
        dec = '0;
        dec.valid = valid;
        dec.rs = instr[25:21];
        dec.rt = instr[20:16];
        dec.jumpIndex = instr[25:0];
        dec.aluOp = cpuPkg::aluAdd;
        unique case (opcode)
            cpuPkg::OP_SPECIAL: begin
                // r-type writes rd
                dec.rd = instr[15:11];
                dec.regWrite = 1'b1;
                case (funct)
                    cpuPkg::FN_ADDU: dec.aluOp = cpuPkg::aluAdd;
                    cpuPkg::FN_SUBU: dec.aluOp = cpuPkg::aluSub;
                    cpuPkg::FN_AND: dec.aluOp = cpuPkg::aluAnd;
                    cpuPkg::FN_OR: dec.aluOp = cpuPkg::aluOr;
                    cpuPkg::FN_XOR: dec.aluOp = cpuPkg::aluXor;
                    cpuPkg::FN_SLT: dec.aluOp = cpuPkg::aluSlt;
                    cpuPkg::FN_SLL: dec.aluOp = cpuPkg::aluSll;
                    cpuPkg::FN_SRL: dec.aluOp = cpuPkg::aluSrl;
                    cpuPkg::FN_JR: begin
                        dec.isJr = 1'b1;
                        dec.regWrite = 1'b0;
                    end
                    // unknown funct acts as nop
                    default: dec.regWrite = 1'b0;
                endcase
            end
            cpuPkg::OP_ADDIU: begin
                dec.rd = instr[20:16];
                dec.regWrite = 1'b1;
                dec.useImm = 1'b1;
                dec.signExt = 1'b1;
                dec.aluOp = cpuPkg::aluAdd;
            end
            cpuPkg::OP_ANDI: begin
                dec.rd = instr[20:16];
                dec.regWrite = 1'b1;
                dec.useImm = 1'b1;
                dec.aluOp = cpuPkg::aluAnd;
            end
            cpuPkg::OP_ORI: begin
                dec.rd = instr[20:16];
                dec.regWrite = 1'b1;
                dec.useImm = 1'b1;
                dec.aluOp = cpuPkg::aluOr;
            end
            cpuPkg::OP_LUI: begin
                dec.rd = instr[20:16];
                dec.regWrite = 1'b1;
                dec.aluOp = cpuPkg::aluLui;
            end
            cpuPkg::OP_J: dec.isJump = 1'b1;
            cpuPkg::OP_JAL: begin
                dec.isJump = 1'b1;
                dec.rd = cpuPkg::RA_REG;
                dec.regWrite = 1'b1;
                dec.aluOp = cpuPkg::aluPassPc8;
            end
            default: dec.regWrite = 1'b0;
        endcase
        // an empty lane has no side effects
        dec.regWrite = dec.regWrite & valid;
        dec.isJump = dec.isJump & valid;
        dec.isJr = dec.isJr & valid;
    end

    // j and jr come from separate opcodes
    always_comb begin
        assert (!(dec.isJump && dec.isJr));
    end

endmodule

//--- hw/cpuPkg.sv
package cpuPkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [31:0] instr_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J = 6'h02;
    localparam logic [5:0] OP_JAL = 6'h03;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI = 6'h0c;
    localparam logic [5:0] OP_ORI = 6'h0d;
    localparam logic [5:0] OP_LUI = 6'h0f;

    // funct field, special opcode only
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_JR = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    // link register for jal
    localparam regAddr_t RA_REG = 5'd31;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluLui,
        // return address for jal
        aluPassPc8
    } aluOp_t;

    // one fetched lane
    typedef struct packed {
        logic valid;
        word_t pc;
        instr_t instr;
    } fetchData_t;

    // one decoded lane
    typedef struct packed {
        logic valid;
        word_t pc;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        logic [15:0] imm;
        logic [4:0] shamt;
        aluOp_t aluOp;
        logic useImm;
        logic signExt;
        logic regWrite;
        logic isJump;
        logic isJr;
        logic [25:0] jumpIndex;
        logic isSlot;
    } decodeData_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        regAddr_t rd;
        logic regWrite;
        word_t result;
        logic isSlot;
    } execData_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        regAddr_t rd;
        logic regWrite;
        word_t data;
        logic isSlot;
    } commitData_t;

endpackage
